//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pager
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
pager_cfg_pkg.sv
page_format_pkg.sv
page_csr.sv
walk_fsm.sv
walk_level.sv
walk_datapath.sv
bus_arbiter.sv
pager_top.sv
tb_pager.sv

//--- bus_arbiter.sv
// memory-op bus arbiter: fixed priority grant, lowest channel wins, blocked by bus_hold
module bus_arbiter (
  input  logic                                                         bus_hold,
  input  logic [pager_cfg_pkg::n_chan-1:0]                             want,
  input  logic [pager_cfg_pkg::n_chan-1:0][pager_cfg_pkg::paddr_width-1:0] pte_addr,
  output logic [pager_cfg_pkg::n_chan-1:0]                             grant,
  output logic [pager_cfg_pkg::n_chan-1:0]                             req_bus,
  output logic                                                         mop_en,
  output logic [pager_cfg_pkg::paddr_width-1:0]                        mop_addr,
  output logic [pager_cfg_pkg::tag_width-1:0]                          mop_register
);

  always_comb begin
    logic found;
    int   tag_sum;

    found = 1'b0;
    tag_sum = 0;
    grant = '0;
    mop_addr = '0;
    mop_register = '0;
    for (int c = 0; c < pager_cfg_pkg::n_chan; c++) begin
      if (want[c] && !bus_hold && !found) begin
        found = 1'b1;
        grant[c] = 1'b1;
        mop_addr = pte_addr[c];
        tag_sum = pager_cfg_pkg::tag_base + c;
        mop_register = tag_sum[pager_cfg_pkg::tag_width-1:0];
      end
    end
  end

  // one-hot request toward the bus owner
  assign req_bus = grant;
  assign mop_en = |grant;

endmodule

//--- page_csr.sv
// page table control registers: two base pointers and the paging enable flag
module page_csr (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      msrss_en,
  input  logic [pager_cfg_pkg::csr_no_width-1:0]    msrss_no,
  input  logic [page_format_pkg::pte_width-1:0]     msrss_data,
  output logic [pager_cfg_pkg::ppn_width-1:0]       base0,
  output logic [pager_cfg_pkg::ppn_width-1:0]       base1,
  output logic                                      paging_en
);

  logic wr_page0;
  logic wr_page1;

  assign wr_page0 = msrss_en && (msrss_no == pager_cfg_pkg::csr_page0);
  assign wr_page1 = msrss_en && (msrss_no == pager_cfg_pkg::csr_page1);

  always_ff @(posedge clk) begin
    if (rst) begin
      base0 <= '0;
      base1 <= '0;
      paging_en <= 1'b0;
    end else begin
      // only the table page is kept, offset bits dropped
      if (wr_page0) begin
        base0 <= msrss_data[pager_cfg_pkg::page_bits +: pager_cfg_pkg::ppn_width];
      end
      if (wr_page1) begin
        base1 <= msrss_data[pager_cfg_pkg::page_bits +: pager_cfg_pkg::ppn_width];
      end
      // sticky until reset
      if (wr_page0 || wr_page1) begin
        paging_en <= 1'b1;
      end
    end
  end

endmodule

//--- page_format_pkg.sv
// page format package: page-table entry bits, TLB entry layout and unmapped attributes
package page_format_pkg;

  localparam int pte_width = 64;

  // attribute bits of a page-table entry
  localparam int pte_present = 0;
  localparam int pte_write = 1;
  localparam int pte_user = 2;
  localparam int pte_noexec = 3;

  // physical page field
  localparam int pte_ppn_lsb = 14;
  localparam int pte_ppn_msb = 43;

  // tlb entry is {ppn[29:0], valid, write, user, noexec}
  localparam int tlb_data_width = 34;
  localparam int tlb_attr_width = 4;

  // attributes while paging is off
  localparam logic [tlb_attr_width-1:0] bypass_attr_user = 4'b1110;
  localparam logic [tlb_attr_width-1:0] bypass_attr_sys = 4'b1100;

endpackage

//--- pager_cfg_pkg.sv
// pager config package: channel count, address widths, level layout and register tags
package pager_cfg_pkg;

  localparam int n_chan = 3;

  localparam int vaddr_width = 48;
  localparam int paddr_width = 44;
  localparam int page_bits = 14;

  // virtual page is vaddr[43:14]
  localparam int vpn_width = 30;
  localparam int ppn_width = 30;

  // bit 43 picks one of the two table bases
  localparam int table_sel_bit = 43;

  localparam int n_levels = 3;
  localparam int level_width = 2;

  // level 2 and 1 use 10 index bits, level 0 only 9
  localparam int index_width = 10;
  localparam int l0_index_width = 9;

  // one tag per channel, counting up from tag_base
  localparam int tag_width = 9;
  localparam int tag_base = 'h1fc;

  localparam int csr_no_width = 16;
  localparam logic [csr_no_width-1:0] csr_page0 = 16'h0c10;
  localparam logic [csr_no_width-1:0] csr_page1 = 16'h0c11;

endpackage

//--- pager_top.sv
// page-table walker top: control registers, bus arbiter and one walk slice per channel
module pager_top (
  input  logic                                                           clk,
  input  logic                                                           rst,
  input  logic [pager_cfg_pkg::n_chan-1:0]                               new_en,
  input  logic [pager_cfg_pkg::n_chan-1:0][pager_cfg_pkg::vaddr_width-1:0] new_addr,
  output logic [pager_cfg_pkg::n_chan-1:0]                               new_can,
  input  logic                                                           msrss_en,
  input  logic [pager_cfg_pkg::csr_no_width-1:0]                         msrss_no,
  input  logic [page_format_pkg::pte_width-1:0]                          msrss_data,
  input  logic                                                           bus_hold,
  output logic [pager_cfg_pkg::n_chan-1:0]                               req_bus,
  output logic                                                           mop_en,
  output logic [pager_cfg_pkg::paddr_width-1:0]                          mop_addr,
  output logic [pager_cfg_pkg::tag_width-1:0]                            mop_register,
  input  logic                                                           fu_hit,
  input  logic [pager_cfg_pkg::tag_width-1:0]                            fu_reg,
  input  logic [page_format_pkg::pte_width-1:0]                          data_in,
  output logic [pager_cfg_pkg::n_chan-1:0]                               tlb_wen,
  output logic [pager_cfg_pkg::n_chan-1:0][pager_cfg_pkg::vpn_width-1:0] tlb_vpn,
  output logic [pager_cfg_pkg::n_chan-1:0][page_format_pkg::tlb_data_width-1:0] tlb_data
);

  logic [pager_cfg_pkg::ppn_width-1:0]                                base0;
  logic [pager_cfg_pkg::ppn_width-1:0]                                base1;
  logic                                                               paging_en;
  logic [pager_cfg_pkg::n_chan-1:0]                                   want;
  logic [pager_cfg_pkg::n_chan-1:0]                                   grant;
  logic [pager_cfg_pkg::n_chan-1:0][pager_cfg_pkg::paddr_width-1:0]   pte_addr;

  page_csr u_csr (
    .clk        (clk),
    .rst        (rst),
    .msrss_en   (msrss_en),
    .msrss_no   (msrss_no),
    .msrss_data (msrss_data),
    .base0      (base0),
    .base1      (base1),
    .paging_en  (paging_en)
  );

  bus_arbiter u_arb (
    .bus_hold     (bus_hold),
    .want         (want),
    .pte_addr     (pte_addr),
    .grant        (grant),
    .req_bus      (req_bus),
    .mop_en       (mop_en),
    .mop_addr     (mop_addr),
    .mop_register (mop_register)
  );

  for (genvar c = 0; c < pager_cfg_pkg::n_chan; c++) begin : g_chan
    logic                                      load;
    logic                                      step;
    logic                                      finish;
    logic                                      last;
    logic                                      present;
    logic [pager_cfg_pkg::index_width-1:0]     index;
    logic [pager_cfg_pkg::vaddr_width-1:0]     vaddr;

    walk_fsm #(.chan(c)) u_fsm (
      .clk       (clk),
      .rst       (rst),
      .new_en    (new_en[c]),
      .paging_en (paging_en),
      .grant     (grant[c]),
      .fu_hit    (fu_hit),
      .fu_reg    (fu_reg),
      .present   (present),
      .last      (last),
      .new_can   (new_can[c]),
      .want      (want[c]),
      .load      (load),
      .step      (step),
      .finish    (finish),
      .tlb_wen   (tlb_wen[c])
    );

    walk_level u_level (
      .clk   (clk),
      .rst   (rst),
      .load  (load),
      .step  (step),
      .vaddr (vaddr),
      .last  (last),
      .index (index)
    );

    walk_datapath u_dp (
      .clk       (clk),
      .rst       (rst),
      .load      (load),
      .step      (step),
      .finish    (finish),
      .new_addr  (new_addr[c]),
      .paging_en (paging_en),
      .base0     (base0),
      .base1     (base1),
      .index     (index),
      .data_in   (data_in),
      .vaddr     (vaddr),
      .present   (present),
      .pte_addr  (pte_addr[c]),
      .tlb_vpn   (tlb_vpn[c]),
      .tlb_data  (tlb_data[c])
    );
  end

endmodule

//--- tb_pager.sv
// page-table walker testbench: random walks against a table memory model and a reference walk
module tb_pager;

  localparam int n_bypass = 12;
  localparam int n_paged = 150;
  localparam int timeout_cycles = (n_bypass + n_paged) * 120 + 560;
  localparam int nc = pager_cfg_pkg::n_chan;
  localparam int aw = pager_cfg_pkg::paddr_width;

  logic clk;
  logic rst;
  logic [nc-1:0] new_en;
  logic [nc-1:0][pager_cfg_pkg::vaddr_width-1:0] new_addr;
  logic [nc-1:0] new_can;
  logic msrss_en;
  logic [pager_cfg_pkg::csr_no_width-1:0] msrss_no;
  logic [page_format_pkg::pte_width-1:0] msrss_data;
  logic bus_hold;
  logic [nc-1:0] req_bus;
  logic mop_en;
  logic [aw-1:0] mop_addr;
  logic [pager_cfg_pkg::tag_width-1:0] mop_register;
  logic fu_hit;
  logic [pager_cfg_pkg::tag_width-1:0] fu_reg;
  logic [page_format_pkg::pte_width-1:0] data_in;
  logic [nc-1:0] tlb_wen;
  logic [nc-1:0][pager_cfg_pkg::vpn_width-1:0] tlb_vpn;
  logic [nc-1:0][page_format_pkg::tlb_data_width-1:0] tlb_data;

  // reference walk state
  logic [nc-1:0] busy;
  logic [nc-1:0] need;
  logic [nc-1:0] resume;
  logic [nc-1:0] exp_wen;
  logic [nc-1:0] exp_req;
  logic paging_on;
  logic [pager_cfg_pkg::ppn_width-1:0] base0_ref;
  logic [pager_cfg_pkg::ppn_width-1:0] base1_ref;
  logic [pager_cfg_pkg::ppn_width-1:0] ref_tab [nc];
  logic [pager_cfg_pkg::vaddr_width-1:0] ref_va [nc];
  int ref_lvl [nc];
  logic [nc-1:0][pager_cfg_pkg::vpn_width-1:0] exp_vpn;
  logic [nc-1:0][page_format_pkg::tlb_data_width-1:0] exp_data;
  logic [aw-1:0] exp_mop_addr;
  logic [pager_cfg_pkg::tag_width-1:0] exp_tag;

  // stimulus control and memory model queues
  logic launch_on;
  logic hold_on;
  int target;
  int accepted;
  int done;
  int cycles;
  int err_value;
  int err_other;
  logic [31:0] rng_state;
  int due_q[$];
  logic [aw-1:0] addr_q[$];
  logic [pager_cfg_pkg::tag_width-1:0] tag_q[$];

  pager_top dut0 (
    .clk (clk), .rst (rst), .new_en (new_en), .new_addr (new_addr), .new_can (new_can),
    .msrss_en (msrss_en), .msrss_no (msrss_no), .msrss_data (msrss_data),
    .bus_hold (bus_hold), .req_bus (req_bus), .mop_en (mop_en), .mop_addr (mop_addr),
    .mop_register (mop_register), .fu_hit (fu_hit), .fu_reg (fu_reg), .data_in (data_in),
    .tlb_wen (tlb_wen), .tlb_vpn (tlb_vpn), .tlb_data (tlb_data)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // table contents as a fixed function of the entry address
  function automatic logic [page_format_pkg::pte_width-1:0] table_entry(input logic [aw-1:0] a);
    logic [page_format_pkg::pte_width-1:0] e;
    e = '0;
    e[43:14] = a[43:14] ^ {a[13:4], a[13:4], a[13:4]} ^ 30'h15a3c96b;
    e[page_format_pkg::pte_write] = a[6];
    e[page_format_pkg::pte_user] = a[7];
    e[page_format_pkg::pte_noexec] = a[8];
    e[page_format_pkg::pte_present] = (a[5:3] != 3'd7);
    return e;
  endfunction

  function automatic logic [aw-1:0] entry_addr(input logic [29:0] tab, input logic [47:0] va,
                                               input int lvl);
    logic [9:0] idx;
    if (lvl == 2) idx = va[42:33];
    else if (lvl == 1) idx = va[32:23];
    else idx = {1'b0, va[22:14]};
    return {tab, 1'b0, idx, 3'b000};
  endfunction

  task automatic print_counts();
    $display("walks %0d of %0d, value errors %0d, other errors %0d",
             done, accepted, err_value, err_other);
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // drives new requests, bus_hold and the table memory responses
  always @(posedge clk) begin
    logic [31:0] r_hi;
    logic [31:0] r_lo;
    logic [47:0] va;
    int lat;
    if (!rst) begin
      for (int c = 0; c < nc; c++) begin
        rng_state = xorshift(rng_state);
        r_hi = rng_state;
        rng_state = xorshift(rng_state);
        r_lo = rng_state;
        va = {r_hi[15:0], r_lo};
        // some addresses in the supervisor region
        if (r_hi[21:20] == 2'b00) va[43:40] = 4'hf;
        new_en[c] <= launch_on && r_hi[16] && (accepted < target);
        new_addr[c] <= va;
      end
      rng_state = xorshift(rng_state);
      bus_hold <= hold_on && rng_state[0];
      lat = int'(rng_state[2:1]) + 1;
      fu_hit <= 1'b0;
      if (mop_en) begin
        due_q.push_back(cycles + lat);
        addr_q.push_back(mop_addr);
        tag_q.push_back(mop_register);
      end
      if (due_q.size() > 0 && due_q[0] <= cycles) begin
        fu_hit <= 1'b1;
        fu_reg <= tag_q[0];
        data_in <= table_entry(addr_q[0]);
        void'(due_q.pop_front());
        void'(addr_q.pop_front());
        void'(tag_q.pop_front());
      end
    end
  end

  // reference walk, one step per observed event
  always @(posedge clk) begin
    int ch;
    int n_acc;
    int n_done;
    logic [page_format_pkg::pte_width-1:0] pte;
    if (rst) begin
      busy <= '0;
      need <= '0;
      resume <= '0;
      exp_wen <= '0;
      paging_on <= 1'b0;
      base0_ref <= '0;
      base1_ref <= '0;
      accepted <= 0;
      done <= 0;
    end else begin
      n_acc = 0;
      n_done = 0;
      exp_wen <= '0;
      resume <= '0;
      if (msrss_en && msrss_no == pager_cfg_pkg::csr_page0) begin
        base0_ref <= msrss_data[43:14];
        paging_on <= 1'b1;
      end
      if (msrss_en && msrss_no == pager_cfg_pkg::csr_page1) begin
        base1_ref <= msrss_data[43:14];
        paging_on <= 1'b1;
      end
      for (int c = 0; c < nc; c++) begin
        if (resume[c]) need[c] <= 1'b1;
        if (req_bus[c]) need[c] <= 1'b0;
        if (exp_wen[c]) begin
          busy[c] <= 1'b0;
          n_done++;
        end
        if (new_en[c] && !busy[c]) begin
          n_acc++;
          busy[c] <= 1'b1;
          ref_va[c] <= new_addr[c];
          ref_lvl[c] <= 2;
          ref_tab[c] <= new_addr[c][43] ? base1_ref : base0_ref;
          exp_vpn[c] <= new_addr[c][43:14];
          if (paging_on) begin
            need[c] <= 1'b1;
          end else begin
            exp_wen[c] <= 1'b1;
            exp_data[c] <= {new_addr[c][43:14], (&new_addr[c][43:40]) ?
                            page_format_pkg::bypass_attr_sys : page_format_pkg::bypass_attr_user};
          end
        end
      end
      if (fu_hit) begin
        ch = int'(fu_reg) - pager_cfg_pkg::tag_base;
        pte = table_entry(entry_addr(ref_tab[ch], ref_va[ch], ref_lvl[ch]));
        if (!pte[0] || ref_lvl[ch] == 0) begin
          exp_wen[ch] <= 1'b1;
          exp_data[ch] <= pte[0] ? {pte[43:14], 1'b1, pte[1], pte[2], pte[3]} : '0;
        end else begin
          ref_tab[ch] <= pte[43:14];
          ref_lvl[ch] <= ref_lvl[ch] - 1;
          resume[ch] <= 1'b1;
        end
      end
      accepted <= accepted + n_acc;
      done <= done + n_done;
    end
  end

  // lowest waiting channel wins unless the bus is held
  assign exp_req = bus_hold ? '0 : (need & (~need + 3'd1));

  always_comb begin
    exp_mop_addr = '0;
    exp_tag = '0;
    for (int c = 0; c < nc; c++) begin
      if (exp_req[c]) begin
        exp_mop_addr = entry_addr(ref_tab[c], ref_va[c], ref_lvl[c]);
        exp_tag = pager_cfg_pkg::tag_width'(pager_cfg_pkg::tag_base + c);
      end
    end
  end

  a_hold: assert property (@(posedge clk) disable iff (rst) !(mop_en && bus_hold))
    else begin
      err_other = err_other + 1;
      $display("t=%0t: memory op issued while bus_hold is high", $time);
    end

  a_req: assert property (@(posedge clk) disable iff (rst) req_bus == exp_req)
    else begin
      err_value = err_value + 1;
      $display("CHECK FAILED t=%0t req_bus got %b expected %b", $time,
               $sampled(req_bus), $sampled(exp_req));
    end

  a_addr: assert property (@(posedge clk) disable iff (rst) mop_en |-> mop_addr == exp_mop_addr)
    else begin
      err_value = err_value + 1;
      $display("CHECK FAILED t=%0t mop_addr got %h expected %h", $time,
               $sampled(mop_addr), $sampled(exp_mop_addr));
    end

  a_tag: assert property (@(posedge clk) disable iff (rst) mop_en |-> mop_register == exp_tag)
    else begin
      err_value = err_value + 1;
      $display("CHECK FAILED t=%0t mop_register got %h expected %h", $time,
               $sampled(mop_register), $sampled(exp_tag));
    end

  for (genvar c = 0; c < nc; c++) begin : g_chk
    a_wen: assert property (@(posedge clk) disable iff (rst) tlb_wen[c] == exp_wen[c])
      else begin
        err_value = err_value + 1;
        $display("CHECK FAILED t=%0t tlb_wen[%0d] got %b expected %b", $time, c,
                 $sampled(tlb_wen[c]), $sampled(exp_wen[c]));
      end
    a_can: assert property (@(posedge clk) disable iff (rst) new_can[c] == !busy[c])
      else begin
        err_value = err_value + 1;
        $display("CHECK FAILED t=%0t new_can[%0d] got %b expected %b", $time, c,
                 $sampled(new_can[c]), !$sampled(busy[c]));
      end
    a_vpn: assert property (@(posedge clk) disable iff (rst)
                            tlb_wen[c] |-> tlb_vpn[c] == exp_vpn[c])
      else begin
        err_value = err_value + 1;
        $display("CHECK FAILED t=%0t tlb_vpn[%0d] got %h expected %h", $time, c,
                 $sampled(tlb_vpn[c]), $sampled(exp_vpn[c]));
      end
    a_data: assert property (@(posedge clk) disable iff (rst)
                             tlb_wen[c] |-> tlb_data[c] == exp_data[c])
      else begin
        err_value = err_value + 1;
        $display("CHECK FAILED t=%0t tlb_data[%0d] got %h expected %h", $time, c,
                 $sampled(tlb_data[c]), $sampled(exp_data[c]));
      end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, walks did not finish", cycles);
      print_counts();
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic run_walks(input int n);
    target <= target + n;
    launch_on <= 1'b1;
    @(posedge clk);
    while (accepted < target) @(posedge clk);
    launch_on <= 1'b0;
    repeat (3) @(posedge clk);
    while (done != accepted || busy != '0) @(posedge clk);
  endtask

  task automatic write_csr(input logic [15:0] no, input logic [63:0] data);
    msrss_en <= 1'b1;
    msrss_no <= no;
    msrss_data <= data;
    @(posedge clk);
    msrss_en <= 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    new_en = '0;
    new_addr = '0;
    msrss_en = 1'b0;
    msrss_no = '0;
    msrss_data = '0;
    bus_hold = 1'b0;
    fu_hit = 1'b0;
    fu_reg = '0;
    data_in = '0;
    launch_on = 1'b0;
    hold_on = 1'b0;
    target = 0;
    cycles = 0;
    err_value = 0;
    err_other = 0;
    rng_state = 32'd83;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    run_walks(n_bypass);
    write_csr(pager_cfg_pkg::csr_page0, 64'h0000_0123_4567_c000);
    write_csr(pager_cfg_pkg::csr_page1, 64'h0000_0fed_cba9_8000);
    hold_on <= 1'b1;
    @(posedge clk);
    run_walks(n_paged);
    repeat (4) @(posedge clk);
    print_counts();
    if (err_value == 0 && err_other == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- walk_datapath.sv
// walk datapath: holds address, table pointer and result, forms entry address and tlb entry
module walk_datapath (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          load,
  input  logic                                          step,
  input  logic                                          finish,
  input  logic [pager_cfg_pkg::vaddr_width-1:0]         new_addr,
  input  logic                                          paging_en,
  input  logic [pager_cfg_pkg::ppn_width-1:0]           base0,
  input  logic [pager_cfg_pkg::ppn_width-1:0]           base1,
  input  logic [pager_cfg_pkg::index_width-1:0]         index,
  input  logic [page_format_pkg::pte_width-1:0]         data_in,
  output logic [pager_cfg_pkg::vaddr_width-1:0]         vaddr,
  output logic                                          present,
  output logic [pager_cfg_pkg::paddr_width-1:0]         pte_addr,
  output logic [pager_cfg_pkg::vpn_width-1:0]           tlb_vpn,
  output logic [page_format_pkg::tlb_data_width-1:0]    tlb_data
);

  localparam int sel = pager_cfg_pkg::table_sel_bit;
  localparam int pg = pager_cfg_pkg::page_bits;

  logic [pager_cfg_pkg::ppn_width-1:0]          table_ppn;
  logic [pager_cfg_pkg::ppn_width-1:0]          res_ppn;
  logic [page_format_pkg::tlb_attr_width-1:0]   res_attr;
  logic [pager_cfg_pkg::ppn_width-1:0]          entry_ppn;
  logic [page_format_pkg::tlb_attr_width-1:0]   entry_attr;
  logic [page_format_pkg::tlb_attr_width-1:0]   bypass_attr;

  assign present = data_in[page_format_pkg::pte_present];
  assign entry_ppn = data_in[page_format_pkg::pte_ppn_msb:page_format_pkg::pte_ppn_lsb];
  assign entry_attr = {
    1'b1,
    data_in[page_format_pkg::pte_write],
    data_in[page_format_pkg::pte_user],
    data_in[page_format_pkg::pte_noexec]
  };

  // top 1 TiB of the unmapped space is supervisor only
  assign bypass_attr = (&new_addr[sel -: 4]) ? page_format_pkg::bypass_attr_sys :
                                               page_format_pkg::bypass_attr_user;

  always_ff @(posedge clk) begin
    if (load) begin
      vaddr <= new_addr;
      table_ppn <= new_addr[sel] ? base1 : base0;
    end else if (step) begin
      table_ppn <= entry_ppn;
    end
  end

  // result page, identity mapped when paging is off
  always_ff @(posedge clk) begin
    if (load && !paging_en) begin
      res_ppn <= new_addr[pg +: pager_cfg_pkg::ppn_width];
    end else if (finish) begin
      res_ppn <= present ? entry_ppn : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_attr <= '0;
    end else if (load && !paging_en) begin
      res_attr <= bypass_attr;
    end else if (finish) begin
      res_attr <= present ? entry_attr : '0;
    end
  end

  // tables sit in the lower half of their page
  assign pte_addr = {table_ppn, 1'b0, index, 3'b000};

  assign tlb_vpn = vaddr[pg +: pager_cfg_pkg::vpn_width];
  assign tlb_data = {res_ppn, res_attr};

endmodule

//--- walk_fsm.sv
// walk state machine: accepts an address, issues one bus op per level, strobes the tlb write
module walk_fsm #(
  parameter int chan = 0
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 new_en,
  input  logic                                 paging_en,
  input  logic                                 grant,
  input  logic                                 fu_hit,
  input  logic [pager_cfg_pkg::tag_width-1:0]  fu_reg,
  input  logic                                 present,
  input  logic                                 last,
  output logic                                 new_can,
  output logic                                 want,
  output logic                                 load,
  output logic                                 step,
  output logic                                 finish,
  output logic                                 tlb_wen
);

  localparam int own_tag_int = pager_cfg_pkg::tag_base + chan;
  localparam logic [pager_cfg_pkg::tag_width-1:0] own_tag =
    own_tag_int[pager_cfg_pkg::tag_width-1:0];

  typedef enum logic [2:0] {
    st_idle,
    st_request,
    st_wait,
    st_write,
    st_recover
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   resp;

  // tag is only checked while an op is outstanding
  assign resp = (state == st_wait) && fu_hit && (fu_reg == own_tag);

  assign new_can = (state == st_idle);
  assign load = new_can && new_en;
  assign want = (state == st_request);
  assign step = resp && present && !last;
  assign finish = resp && (!present || last);
  assign tlb_wen = (state == st_write);

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (new_en) begin
          state_nxt = paging_en ? st_request : st_write;
        end
      end
      st_request: begin
        if (grant) begin
          state_nxt = st_wait;
        end
      end
      st_wait: begin
        if (step) begin
          state_nxt = st_recover;
        end else if (finish) begin
          state_nxt = st_write;
        end
      end
      // table pointer and level settle before the next op
      st_recover: state_nxt = st_request;
      st_write: state_nxt = st_idle;
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

//--- walk_level.sv
// walk level counter: tracks the table level and picks that level's index field
module walk_level (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    load,
  input  logic                                    step,
  input  logic [pager_cfg_pkg::vaddr_width-1:0]   vaddr,
  output logic                                    last,
  output logic [pager_cfg_pkg::index_width-1:0]   index
);

  localparam int l0_lsb = pager_cfg_pkg::page_bits;
  localparam int l1_lsb = l0_lsb + pager_cfg_pkg::l0_index_width;
  localparam int l2_lsb = l1_lsb + pager_cfg_pkg::index_width;

  logic [pager_cfg_pkg::level_width-1:0] level;

  always_ff @(posedge clk) begin
    if (rst) begin
      level <= '0;
    end else if (load) begin
      level <= pager_cfg_pkg::level_width'(pager_cfg_pkg::n_levels - 1);
    end else if (step) begin
      level <= level - 1'b1;
    end
  end

  assign last = (level == '0);

  always_comb begin
    case (level)
      2'd2: index = vaddr[l2_lsb +: pager_cfg_pkg::index_width];
      2'd1: index = vaddr[l1_lsb +: pager_cfg_pkg::index_width];
      // level 0 field is one bit short
      default: index = {1'b0, vaddr[l0_lsb +: pager_cfg_pkg::l0_index_width]};
    endcase
  end

endmodule
